/* tb.f */
+incdir+.
av_pkg.sv
phase_timer.sv
tft_phase_fsm.sv
tft_pixel_source.sv
apu_pwm.sv
nes_av_top.sv
tb_nes_av_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the AV front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_sim

rm -f "$LOG"

verilator --binary --timing --assert \
	--top-module tb_nes_av_top \
	-f tb.f \
	-o "$BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1

/* tb_nes_av_top.sv */
`timescale 1ns/10ps

`include "av_params.svh"

module tb_nes_av_top;

	import av_pkg::*;

	localparam int FRAME_TIMEOUT = 160000;
	localparam int AUDIO_HOLD = 2048;

	logic                 clk = 1'b0;
	logic                 rst_n;
	pattern_e             pattern;
	logic [`AV_RGB_W-1:0] color;
	logic [7:0]           audio;
	logic                 audio_en;
	logic [`AV_RGB_W-1:0] tft_rgb;
	tft_sync_t            tft_sync;
	logic                 aout;

	int errors = 0;
	int timeouts = 0;
	int aud_tick = 0;
	int vfall_cnt = 0;

	// Reference state rebuilt from the panel lines
	int         rel_cnt = 0;
	int         cyc = 0;
	int         h_low = 0;
	int         v_low = 0;
	int         de_len = 0;
	int         de_runs = 0;
	int         last_hfall = 0;
	int         last_vfall = 0;
	bit         hfall_seen = 1'b0;
	bit         vfall_seen = 1'b0;
	logic       prev_de = 1'b0;
	logic       prev_h = 1'b0;
	logic       prev_v = 1'b0;
	logic [8:0] mx = '0;
	logic [8:0] my = '0;

	// Audio window over the last 256 clocks
	bit         hist [256];
	logic [7:0] hidx = '0;
	int         win_sum = 0;
	int         stable = 0;
	logic [7:0] last_audio = '0;
	logic       last_en = 1'b0;

	nes_av_top u_nes_av_top (
		.clk      (clk),
		.rst_n    (rst_n),
		.pattern  (pattern),
		.color    (color),
		.audio    (audio),
		.audio_en (audio_en),
		.tft_rgb  (tft_rgb),
		.tft_sync (tft_sync),
		.aout     (aout)
	);

	always #50 clk = ~clk;

	task automatic log_mismatch(input string msg);
		errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	// Colour the panel should show at column x, row y
	function automatic logic [23:0] expected_rgb(input pattern_e pat, input logic [23:0] col,
			input logic [8:0] x, input logic [8:0] y);
		int         bar;
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic [23:0] res;
		bar = int'(x) / 60;
		r = ((bar & 4) != 0) ? 8'hff : 8'h00;
		g = ((bar & 2) != 0) ? 8'hff : 8'h00;
		b = ((bar & 1) != 0) ? 8'hff : 8'h00;
		case (pat)
			PAT_SOLID:   res = col;
			PAT_BARS:    res = {r, g, b};
			PAT_CHECKER: res = (x[4] != y[4]) ? 24'hffffff : 24'h000000;
			default:     res = {x[8:1], y[8:1], 8'h00};
		endcase
		return res;
	endfunction

	// New sample and enable every AUDIO_HOLD clocks, zero now and then
	task automatic drive_audio_step;
		aud_tick++;
		if (aud_tick >= AUDIO_HOLD) begin
			aud_tick = 0;
			audio_en = ~audio_en;
			if ($urandom % 4 == 0) begin
				audio = 8'h00;
			end else begin
				audio = 8'($urandom);
			end
		end
	endtask

	task automatic wait_frame_start(output bit ok);
		int n;
		int target;
		n = 0;
		target = vfall_cnt + 1;
		while (vfall_cnt < target && n < FRAME_TIMEOUT) begin
			@(posedge clk);
			#1;
			drive_audio_step();
			n++;
		end
		ok = (vfall_cnt >= target);
		if (!ok) begin
			$display("Timeout: vsync never fell within %0d clocks", FRAME_TIMEOUT);
		end
	endtask

	a_rgb_blank: assert property (@(posedge clk) disable iff (!rst_n)
		(!tft_sync.de |-> tft_rgb == '0))
		else log_mismatch("rgb not zero while de is low");

	a_disp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		($past(tft_sync.disp) |-> tft_sync.disp))
		else log_mismatch("disp dropped after going high");

	// Sample in mid cycle where every DUT output is settled
	always @(negedge clk) begin
		if (!rst_n || rel_cnt == 0) begin
			assert (!tft_sync.de && !tft_sync.disp && !tft_sync.hsync && !tft_sync.vsync)
				else log_mismatch("sync lines not idle around reset");
			rel_cnt = rst_n ? 1 : 0;
			// The sample at release is the first clock of both sync pulses
			h_low = rel_cnt;
			v_low = rel_cnt;
			stable = 0;
		end else begin
			cyc++;
			assert (tft_sync.disp) else log_mismatch("disp low after reset release");
			assert (tft_rgb == (tft_sync.de ? expected_rgb(pattern, color, mx, my) : 24'h0))
				else log_mismatch("rgb does not match the pattern");

			// Horizontal timing
			if (prev_h && !tft_sync.hsync) begin
				if (hfall_seen) begin
					assert (cyc - last_hfall == 525) else log_mismatch("hsync period not 525");
				end
				hfall_seen = 1'b1;
				last_hfall = cyc;
			end
			if (!prev_h && tft_sync.hsync) begin
				assert (h_low == 41) else log_mismatch("hsync low width not 41");
			end
			h_low = tft_sync.hsync ? 0 : h_low + 1;

			// Active runs
			if (tft_sync.de && !prev_de) begin
				assert (hfall_seen && cyc - last_hfall == 43)
					else log_mismatch("de start not 43 clocks after hsync fall");
				de_runs++;
			end
			if (!tft_sync.de && prev_de) begin
				assert (de_len == 480) else log_mismatch("de run not 480 clocks");
			end
			de_len = tft_sync.de ? de_len + 1 : 0;

			// Vertical timing
			if (prev_v && !tft_sync.vsync) begin
				if (vfall_seen) begin
					assert (cyc - last_vfall == 150150)
						else log_mismatch("vsync period not 150150");
					assert (de_runs == 272) else log_mismatch("frame does not hold 272 de runs");
				end
				vfall_seen = 1'b1;
				last_vfall = cyc;
				de_runs = 0;
				vfall_cnt++;
			end
			if (!prev_v && tft_sync.vsync) begin
				assert (v_low == 5250) else log_mismatch("vsync low width not 5250");
			end
			v_low = tft_sync.vsync ? 0 : v_low + 1;

			// Audio duty over a full counter period
			if (audio != last_audio || audio_en != last_en) begin
				stable = 0;
			end else begin
				stable++;
			end
			if (hist[hidx]) begin
				win_sum--;
			end
			if (aout) begin
				win_sum++;
			end
			hist[hidx] = aout;
			hidx = hidx + 8'd1;
			if (stable >= 1 && (!audio_en || audio == 8'h00)) begin
				assert (!aout) else log_mismatch("aout high while muted");
			end else if (stable >= 256 && audio_en) begin
				assert (win_sum == int'(audio)) else log_mismatch("aout duty differs from audio");
			end
		end
		last_audio = audio;
		last_en = audio_en;

		// Position update for the next clock
		if (!rst_n) begin
			mx = '0;
			my = '0;
		end else begin
			if (!tft_sync.vsync) begin
				my = '0;
			end else if (prev_de && !tft_sync.de) begin
				my = my + 9'd1;
			end
			mx = tft_sync.de ? mx + 9'd1 : 9'd0;
		end
		prev_de = rst_n ? tft_sync.de : 1'b0;
		prev_h = tft_sync.hsync;
		prev_v = tft_sync.vsync;
	end

	initial begin
		bit ok;
		int p;
		int f;
		void'($urandom(32'h4a056ebd));
		rst_n = 1'b0;
		pattern = PAT_SOLID;
		color = '0;
		audio = 8'h00;
		audio_en = 1'b0;
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;

		// Frame from release, then two full frames for each pattern
		wait_frame_start(ok);
		for (p = 0; p < 4 && ok; p++) begin
			pattern = pattern_e'(p[1:0]);
			for (f = 0; f < 2 && ok; f++) begin
				color = 24'($urandom);
				wait_frame_start(ok);
			end
		end
		if (!ok) begin
			timeouts++;
		end

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* nes_av_top.sv */
`timescale 1ns/10ps

`include "av_params.svh"

module nes_av_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  av_pkg::pattern_e     pattern,
	input  logic [`AV_RGB_W-1:0] color,
	input  logic [7:0]           audio,
	input  logic                 audio_en,
	output logic [`AV_RGB_W-1:0] tft_rgb,
	output av_pkg::tft_sync_t    tft_sync,
	output logic                 aout
);

	// Panel timing
	tft_phase_fsm u_tft_phase_fsm (
		.clk   (clk),
		.rst_n (rst_n),
		.sync  (tft_sync)
	);

	// Pixel colour, aligned with de
	tft_pixel_source u_tft_pixel_source (
		.clk     (clk),
		.rst_n   (rst_n),
		.sync    (tft_sync),
		.pattern (pattern),
		.color   (color),
		.rgb     (tft_rgb)
	);

	// Audio output
	apu_pwm #(
		.N (8)
	) u_apu_pwm (
		.clk   (clk),
		.rst_n (rst_n),
		.en    (audio_en),
		.cmp   (audio),
		.q     (aout)
	);

endmodule

/* apu_pwm.sv */
`timescale 1ns/10ps

`include "av_params.svh"

module apu_pwm #(
	parameter int N = `AV_PWM_W
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         en,
	input  logic [N-1:0] cmp,
	output logic         q
);

	logic [N-1:0] cnt;

	// Free-running ramp, one period every 2**N clocks
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// High for cmp clocks of each period
	// A zero sample never goes high
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q <= 1'b0;
		end else begin
			q <= en && (cnt < cmp);
		end
	end

endmodule

/* tft_pixel_source.sv */
`timescale 1ns/10ps

`include "av_params.svh"

module tft_pixel_source (
	input  logic                 clk,
	input  logic                 rst_n,
	input  av_pkg::tft_sync_t    sync,
	input  av_pkg::pattern_e     pattern,
	input  logic [`AV_RGB_W-1:0] color,
	output logic [`AV_RGB_W-1:0] rgb
);

	import av_pkg::*;

	pixel_pos_t             pos;
	logic                   de_q;
	logic                   de_fall;
	logic [`AV_COORD_W-1:0] bar_idx;
	logic                   checker_on;
	logic [`AV_RGB_W-1:0]   pat_rgb;

	// End of an active line
	assign de_fall = de_q & ~sync.de;

	// Previous data enable
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			de_q <= 1'b0;
		end else begin
			de_q <= sync.de;
		end
	end

	// Column counts through the active run and drops back outside it
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos.x <= '0;
		end else if (sync.de) begin
			pos.x <= pos.x + 1'b1;
		end else begin
			pos.x <= '0;
		end
	end

	// Row steps once per active line
	// Held at zero through vertical sync
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos.y <= '0;
		end else if (!sync.vsync) begin
			pos.y <= '0;
		end else if (de_fall) begin
			pos.y <= pos.y + 1'b1;
		end
	end

	// Eight bars of 60 columns each
	assign bar_idx = pos.x / 9'd60;

	// 16 pixel squares
	assign checker_on = pos.x[4] ^ pos.y[4];

	// Colour for the selected pattern
	always_comb begin
		case (pattern)
			PAT_SOLID: begin
				pat_rgb = color;
			end
			PAT_BARS: begin
				pat_rgb = {{8{bar_idx[2]}}, {8{bar_idx[1]}}, {8{bar_idx[0]}}};
			end
			PAT_CHECKER: begin
				pat_rgb = {`AV_RGB_W{checker_on}};
			end
			default: begin
				// Red ramps across, green ramps down
				pat_rgb = {pos.x[8:1], pos.y[8:1], 8'h00};
			end
		endcase
	end

	// Black outside the active area
	assign rgb = sync.de ? pat_rgb : '0;

endmodule

/* tft_phase_fsm.sv */
`timescale 1ns/10ps

`include "av_params.svh"

module tft_phase_fsm (
	input  logic               clk,
	input  logic               rst_n,
	output av_pkg::tft_sync_t  sync
);

	import av_pkg::*;

	tft_phase_e             h_state;
	tft_phase_e             v_state;
	logic [`AV_TIMER_W-1:0] h_len;
	logic [`AV_TIMER_W-1:0] v_len;
	logic                   h_expire;
	logic                   v_expire;
	logic                   line_end;
	logic                   disp_q;

	// Phase that follows the given one on either axis
	function automatic tft_phase_e next_phase(input tft_phase_e ph);
		tft_phase_e nxt;
		case (ph)
			PH_SYNC:   nxt = PH_BACK;
			PH_BACK:   nxt = PH_ACTIVE;
			PH_ACTIVE: nxt = PH_FRONT;
			default:   nxt = PH_SYNC;
		endcase
		return nxt;
	endfunction

	// Horizontal phase length in clocks
	always_comb begin
		case (h_state)
			PH_SYNC:   h_len = `AV_H_SYNC;
			PH_BACK:   h_len = `AV_H_BACK;
			PH_ACTIVE: h_len = `AV_H_ACTIVE;
			default:   h_len = `AV_H_FRONT;
		endcase
	end

	// Vertical phase length in lines
	always_comb begin
		case (v_state)
			PH_SYNC:   v_len = `AV_V_SYNC;
			PH_BACK:   v_len = `AV_V_BACK;
			PH_ACTIVE: v_len = `AV_V_ACTIVE;
			default:   v_len = `AV_V_FRONT;
		endcase
	end

	// A line ends when the horizontal front porch runs out
	assign line_end = h_expire & (h_state == PH_FRONT);

	// Pixel clock pacing
	phase_timer u_h_timer (
		.clk    (clk),
		.rst_n  (rst_n),
		.en     (1'b1),
		.length (h_len),
		.expire (h_expire)
	);

	// Line pacing
	phase_timer u_v_timer (
		.clk    (clk),
		.rst_n  (rst_n),
		.en     (line_end),
		.length (v_len),
		.expire (v_expire)
	);

	// Phase state registers
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			h_state <= PH_SYNC;
			v_state <= PH_SYNC;
		end else begin
			if (h_expire) begin
				h_state <= next_phase(h_state);
			end
			if (v_expire) begin
				v_state <= next_phase(v_state);
			end
		end
	end

	// Panel enable comes up once reset is gone
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			disp_q <= 1'b0;
		end else begin
			disp_q <= 1'b1;
		end
	end

	// Decode of the state registers
	always_comb begin
		sync.disp  = disp_q;
		sync.de    = (h_state == PH_ACTIVE) && (v_state == PH_ACTIVE);
		sync.vsync = (v_state != PH_SYNC);
		sync.hsync = (h_state != PH_SYNC);
	end

endmodule

/* phase_timer.sv */
`timescale 1ns/10ps

`include "av_params.svh"

module phase_timer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   en,
	input  logic [`AV_TIMER_W-1:0] length,
	output logic                   expire
);

	logic [`AV_TIMER_W-1:0] count;
	logic                   at_last;

	// Last tick of the phase
	assign at_last = (count == length - 1'b1);

	// Pulse on the enabled tick that ends the phase
	assign expire = en & at_last;

	// Count enabled ticks
	// The count returns to zero at the end of the phase so the
	// following phase starts fresh with its own length
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (en) begin
			if (at_last) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

/* av_pkg.sv */
package av_pkg;

`include "av_params.svh"

	// Timing phase of one axis, in the order the panel walks through them
	typedef enum logic [1:0] {
		PH_SYNC,
		PH_BACK,
		PH_ACTIVE,
		PH_FRONT
	} tft_phase_e;

	// Pixel source selection
	typedef enum logic [1:0] {
		PAT_SOLID,
		PAT_BARS,
		PAT_CHECKER,
		PAT_GRAD
	} pattern_e;

	// Panel control lines
	// hsync and vsync are active low
	typedef struct packed {
		logic disp;
		logic de;
		logic vsync;
		logic hsync;
	} tft_sync_t;

	// Position of the current pixel in the active area
	typedef struct packed {
		logic [`AV_COORD_W-1:0] x;
		logic [`AV_COORD_W-1:0] y;
	} pixel_pos_t;

endpackage

/* av_params.svh */
`ifndef AV_PARAMS_SVH
`define AV_PARAMS_SVH

// Panel timing for the 480x272 TFT on the 10 MHz pixel clock
// Phase lengths are sized to the phase timer count width

// Horizontal phases in pixel clocks
`define AV_H_SYNC   9'd41
`define AV_H_BACK   9'd2
`define AV_H_ACTIVE 9'd480
`define AV_H_FRONT  9'd2

// Vertical phases in lines
`define AV_V_SYNC   9'd10
`define AV_V_BACK   9'd2
`define AV_V_ACTIVE 9'd272
`define AV_V_FRONT  9'd2

// Phase timer count width, wide enough for the 480 clock active phase
`define AV_TIMER_W 9

// Pixel coordinate width, covers both 480 columns and 272 rows
`define AV_COORD_W 9

// Colour word as 8 bits each of red, green and blue
`define AV_RGB_W 24

// Audio sample width and default PWM resolution
`define AV_PWM_W 8

`endif
